// ==== Bender.yml ====
package:
  name: vec_calc

sources:
  - include_dirs:
      - include
    files:
      - design/vec_calc_pkg.sv
      - design/vec_sram.sv
      - design/sram_to_sram_calc_unit.sv
      - design/calc_sequencer.sv
      - design/axil_regs.sv
      - design/vec_calc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/vec_calc_tb.sv

// ==== build.f ====
+incdir+include
design/vec_calc_pkg.sv
design/vec_sram.sv
design/sram_to_sram_calc_unit.sv
design/calc_sequencer.sv
design/axil_regs.sv
design/vec_calc_top.sv
tb/vec_calc_tb.sv

// ==== design/axil_regs.sv ====
`default_nettype none

`include "vec_calc_defs.svh"

module axil_regs (
    input  var logic                    clk,
    input  var logic                    reset,

    input  var vec_calc_pkg::axil_req_t axil_req,
    output var vec_calc_pkg::axil_rsp_t axil_rsp,

    output var logic                    start,
    output var logic [`VC_ROW_BITS-1:0] cfg_src,
    output var logic [`VC_ROW_BITS-1:0] cfg_dst,
    output var logic [`VC_ROW_BITS:0]   cfg_count,
    input  var logic                    busy,
    input  var logic                    done,

    output var vec_calc_pkg::mem_req_t  mem_req,
    input  var vec_calc_pkg::mem_rsp_t  mem_rsp
);

    localparam int         ELEM_BITS   = $clog2(`VC_UNIT_LEN);
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [`VC_AXI_ADDR_BITS-1:0] acc_addr;
    logic                         ready;
    logic                         aw_acc;
    logic                         ar_acc;
    logic                         win_hit;
    logic                         mem_wait;
    logic                         mem_is_write;
    logic                         bvalid_q;
    logic                         rvalid_q;
    logic [1:0]                   bresp_q;
    logic [1:0]                   rresp_q;
    logic [31:0]                  rdata_q;
    logic [31:0]                  reg_rdata;

    // ========================================
    // Address phase and decode
    // ========================================

    assign ready    = !bvalid_q && !rvalid_q && !mem_wait;  // One transaction at a time
    assign aw_acc   = ready && axil_req.awvalid && axil_req.wvalid;
    assign ar_acc   = ready && axil_req.arvalid && !aw_acc;
    assign acc_addr = aw_acc ? axil_req.awaddr : axil_req.araddr;
    assign win_hit  = (acc_addr[`VC_AXI_ADDR_BITS-1:8] == 'h1) ||
                      (acc_addr[`VC_AXI_ADDR_BITS-1:8] == 'h2);

    assign start = aw_acc && !win_hit && (acc_addr == vec_calc_pkg::reg_ctrl) &&
                   axil_req.wdata[0];

    assign mem_req = '{
        valid: (aw_acc || ar_acc) && win_hit,
        write: aw_acc,
        bank:  acc_addr[9],
        row:   acc_addr[4 +: `VC_ROW_BITS],
        elem:  acc_addr[2 +: ELEM_BITS],
        data:  axil_req.wdata[`VC_DATA_BITS-1:0]
    };

    always_comb begin
        reg_rdata = '0;  // Ctrl and unmapped offsets read as zero
        case (acc_addr)
            vec_calc_pkg::reg_status:    reg_rdata[1:0] = {done, busy};
            vec_calc_pkg::reg_src_row:   reg_rdata[`VC_ROW_BITS-1:0] = cfg_src;
            vec_calc_pkg::reg_dst_row:   reg_rdata[`VC_ROW_BITS-1:0] = cfg_dst;
            vec_calc_pkg::reg_row_count: reg_rdata[`VC_ROW_BITS:0] = cfg_count;
            default:                     reg_rdata = '0;
        endcase
    end

    // ========================================
    // Response channels and config registers
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid_q  <= 1'b0;
            rvalid_q  <= 1'b0;
            mem_wait  <= 1'b0;
            cfg_src   <= '0;
            cfg_dst   <= '0;
            cfg_count <= '0;
        end else begin
            if (bvalid_q && axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rvalid_q && axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (aw_acc || ar_acc) begin
                if (win_hit) begin
                    mem_wait <= 1'b1;
                end else if (aw_acc) begin
                    bvalid_q <= 1'b1;
                end else begin
                    rvalid_q <= 1'b1;
                end
            end
            if (mem_wait && mem_rsp.valid) begin
                mem_wait <= 1'b0;
                bvalid_q <= mem_is_write;
                rvalid_q <= !mem_is_write;
            end
            if (aw_acc && !win_hit) begin
                case (acc_addr)
                    vec_calc_pkg::reg_src_row:   cfg_src   <= axil_req.wdata[`VC_ROW_BITS-1:0];
                    vec_calc_pkg::reg_dst_row:   cfg_dst   <= axil_req.wdata[`VC_ROW_BITS-1:0];
                    vec_calc_pkg::reg_row_count: cfg_count <= axil_req.wdata[`VC_ROW_BITS:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_acc || ar_acc) begin
            mem_is_write <= aw_acc;
        end
        if (aw_acc && !win_hit) begin
            bresp_q <= RESP_OKAY;
        end
        if (ar_acc && !win_hit) begin
            rresp_q <= RESP_OKAY;
            rdata_q <= reg_rdata;
        end
        if (mem_wait && mem_rsp.valid) begin
            bresp_q <= mem_rsp.err ? RESP_SLVERR : RESP_OKAY;
            rresp_q <= mem_rsp.err ? RESP_SLVERR : RESP_OKAY;
            rdata_q <= {{(32-`VC_DATA_BITS){mem_rsp.data[`VC_DATA_BITS-1]}}, mem_rsp.data};
        end
    end

    assign axil_rsp = '{
        awready: aw_acc,
        wready:  aw_acc,
        bvalid:  bvalid_q,
        bresp:   bresp_q,
        arready: ar_acc,
        rdata:   rdata_q,
        rvalid:  rvalid_q,
        rresp:   rresp_q
    };

endmodule

`default_nettype wire

// ==== design/calc_sequencer.sv ====
`default_nettype none

`include "vec_calc_defs.svh"

module calc_sequencer (
    input  var logic                    clk,
    input  var logic                    reset,

    input  var logic                    start,
    input  var logic [`VC_ROW_BITS-1:0] cfg_src,
    input  var logic [`VC_ROW_BITS-1:0] cfg_dst,
    input  var logic [`VC_ROW_BITS:0]   cfg_count,
    output var logic                    busy,
    output var logic                    done,

    input  var vec_calc_pkg::mem_req_t  host_req,
    output var vec_calc_pkg::mem_rsp_t  host_rsp,

    output var logic                    rd_en,
    output var logic [`VC_ROW_BITS-1:0] rd_row,
    input  var vec_calc_pkg::row_t      rd_a,
    input  var vec_calc_pkg::row_t      rd_b,

    output var logic                    a_wr_en,
    output var logic                    b_wr_en,
    output var logic [`VC_ROW_BITS-1:0] wr_row,
    output var logic [`VC_UNIT_LEN-1:0] wr_mask,
    output var vec_calc_pkg::row_t      wr_a,
    output var vec_calc_pkg::row_t      wr_b,

    output var vec_calc_pkg::row_pair_t calc_in,
    output var logic                    calc_in_valid,
    input  var vec_calc_pkg::row_pair_t calc_out,
    input  var logic                    calc_out_valid
);

    vec_calc_pkg::seq_state_t          state;
    logic [`VC_ROW_BITS-1:0]           rd_ptr;
    logic [`VC_ROW_BITS-1:0]           wr_ptr;
    logic [`VC_ROW_BITS:0]             count_q;
    logic [`VC_ROW_BITS:0]             rd_cnt;
    logic [`VC_ROW_BITS:0]             wr_cnt;
    logic                              eng_rd_q;
    logic                              host_acc;
    logic                              hrd_q;
    logic                              hrd_bank;
    logic [$clog2(`VC_UNIT_LEN)-1:0]   hrd_elem;
    logic                              rsp_valid_q;
    logic                              rsp_err_q;
    vec_calc_pkg::elem_t               rsp_data_q;

    assign host_acc      = host_req.valid && (state == vec_calc_pkg::seq_idle);
    assign busy          = (state != vec_calc_pkg::seq_idle);
    assign calc_in       = '{d0: rd_a, d1: rd_b};
    assign calc_in_valid = eng_rd_q;  // Bank data lands one cycle after an engine read
    assign host_rsp      = '{valid: rsp_valid_q, err: rsp_err_q, data: rsp_data_q};

    // ========================================
    // Engine FSM
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= vec_calc_pkg::seq_idle;
            done        <= 1'b0;
            eng_rd_q    <= 1'b0;
            hrd_q       <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            eng_rd_q    <= (state == vec_calc_pkg::seq_run);
            hrd_q       <= host_acc && !host_req.write;
            rsp_valid_q <= hrd_q || (host_req.valid && !(host_acc && !host_req.write));
            case (state)
                vec_calc_pkg::seq_idle: begin
                    if (start && cfg_count != '0) begin
                        state <= vec_calc_pkg::seq_run;
                        done  <= 1'b0;
                    end
                end
                vec_calc_pkg::seq_run: begin
                    if (rd_cnt == count_q - 1'b1) begin
                        state <= vec_calc_pkg::seq_drain;
                    end
                end
                vec_calc_pkg::seq_drain: begin
                    if (calc_out_valid && wr_cnt == count_q - 1'b1) begin
                        state <= vec_calc_pkg::seq_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= vec_calc_pkg::seq_idle;
            endcase
        end
    end

    // Row pointers and counters are loaded on every start seen while idle
    always_ff @(posedge clk) begin
        if (state == vec_calc_pkg::seq_idle && start) begin
            rd_ptr  <= cfg_src;
            wr_ptr  <= cfg_dst;
            count_q <= cfg_count;
            rd_cnt  <= '0;
            wr_cnt  <= '0;
        end else begin
            if (state == vec_calc_pkg::seq_run) begin
                rd_ptr <= rd_ptr + 1'b1;
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (calc_out_valid) begin
                wr_ptr <= wr_ptr + 1'b1;  // Results come back in read order
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // ========================================
    // Host access path
    // ========================================

    always_ff @(posedge clk) begin
        if (host_acc) begin
            hrd_bank <= host_req.bank;
            hrd_elem <= host_req.elem;
        end
        if (hrd_q) begin
            rsp_err_q  <= 1'b0;
            rsp_data_q <= hrd_bank ? rd_b[hrd_elem] : rd_a[hrd_elem];
        end else begin
            rsp_err_q  <= !host_acc;  // Refused while the engine runs
            rsp_data_q <= '0;
        end
    end

    always_comb begin
        rd_en   = (state == vec_calc_pkg::seq_run) || (host_acc && !host_req.write);
        rd_row  = (state == vec_calc_pkg::seq_run) ? rd_ptr : host_req.row;
        a_wr_en = calc_out_valid || (host_acc && host_req.write && !host_req.bank);
        b_wr_en = calc_out_valid || (host_acc && host_req.write && host_req.bank);
        if (calc_out_valid) begin
            wr_row  = wr_ptr;
            wr_mask = '1;
            wr_a    = calc_out.d0;
            wr_b    = calc_out.d1;
        end else begin
            wr_row                 = host_req.row;
            wr_mask                = '0;
            wr_mask[host_req.elem] = 1'b1;
            wr_a                   = {`VC_UNIT_LEN{host_req.data}};
            wr_b                   = {`VC_UNIT_LEN{host_req.data}};
        end
    end

endmodule

`default_nettype wire

// ==== design/sram_to_sram_calc_unit.sv ====
`default_nettype none

`include "vec_calc_defs.svh"

module sram_to_sram_calc_unit #(
    parameter bit INSERT_PRE_FF  = 0,
    parameter bit INSERT_POST_FF = 0
) (
    input  var logic                    reset,
    input  var logic                    clk,

    input  var vec_calc_pkg::row_pair_t s_pair,
    input  var logic                    s_valid,

    output var vec_calc_pkg::row_pair_t m_pair,
    output var logic                    m_valid
);

    vec_calc_pkg::row_pair_t st0_pair;
    vec_calc_pkg::row_pair_t st1_pair;
    vec_calc_pkg::row_pair_t st2_pair;
    logic                    st0_valid;
    logic                    st1_valid;
    logic                    st2_valid;

    // ========================================
    // Stage 0, optional input register
    // ========================================

    if (INSERT_PRE_FF) begin : g_pre_ff
        always_ff @(posedge clk) begin
            if (reset) begin
                st0_valid <= 1'b0;
            end else begin
                st0_valid <= s_valid;
            end
        end

        always_ff @(posedge clk) begin
            st0_pair <= s_pair;
        end
    end else begin : g_pre_wire
        assign st0_pair  = s_pair;
        assign st0_valid = s_valid;
    end

    // ========================================
    // Stage 1, element-wise add and shift-add
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            st1_valid <= 1'b0;
        end else begin
            st1_valid <= st0_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `VC_UNIT_LEN; i++) begin
            st1_pair.d0[i] <= st0_pair.d0[i] + (st0_pair.d1[i] >>> 1);  // Sign kept by >>>
            st1_pair.d1[i] <= st0_pair.d0[i] + st0_pair.d1[i];
        end
    end

    // ========================================
    // Stage 2, optional output register
    // ========================================

    if (INSERT_POST_FF) begin : g_post_ff
        always_ff @(posedge clk) begin
            if (reset) begin
                st2_valid <= 1'b0;
            end else begin
                st2_valid <= st1_valid;
            end
        end

        always_ff @(posedge clk) begin
            st2_pair <= st1_pair;
        end
    end else begin : g_post_wire
        assign st2_pair  = st1_pair;
        assign st2_valid = st1_valid;
    end

    assign m_pair  = st2_pair;
    assign m_valid = st2_valid;

endmodule

`default_nettype wire

// ==== design/vec_calc_pkg.sv ====
`default_nettype none

`include "vec_calc_defs.svh"

package vec_calc_pkg;

    typedef logic signed [`VC_DATA_BITS-1:0] elem_t;
    typedef elem_t [`VC_UNIT_LEN-1:0] row_t;

    typedef struct packed {
        row_t d0;
        row_t d1;
    } row_pair_t;

    typedef struct packed {
        logic                            valid;
        logic                            write;
        logic                            bank;  // 0 selects bank A
        logic [`VC_ROW_BITS-1:0]         row;
        logic [$clog2(`VC_UNIT_LEN)-1:0] elem;
        elem_t                           data;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        logic  err;
        elem_t data;
    } mem_rsp_t;

    typedef struct packed {
        logic [`VC_AXI_ADDR_BITS-1:0] awaddr;
        logic                         awvalid;
        logic [31:0]                  wdata;
        logic [3:0]                   wstrb;
        logic                         wvalid;
        logic                         bready;
        logic [`VC_AXI_ADDR_BITS-1:0] araddr;
        logic                         arvalid;
        logic                         rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic [31:0] rdata;
        logic        rvalid;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_run,
        seq_drain
    } seq_state_t;

    typedef enum logic [`VC_AXI_ADDR_BITS-1:0] {
        reg_ctrl      = 'h000,
        reg_status    = 'h004,
        reg_src_row   = 'h008,
        reg_dst_row   = 'h00C,
        reg_row_count = 'h010
    } reg_addr_t;

endpackage

`default_nettype wire

// ==== design/vec_calc_top.sv ====
`default_nettype none

`include "vec_calc_defs.svh"

module vec_calc_top (
    input  var logic                    clk,
    input  var logic                    reset,
    input  var vec_calc_pkg::axil_req_t axil_req,
    output var vec_calc_pkg::axil_rsp_t axil_rsp
);

    logic                    start;
    logic [`VC_ROW_BITS-1:0] cfg_src;
    logic [`VC_ROW_BITS-1:0] cfg_dst;
    logic [`VC_ROW_BITS:0]   cfg_count;
    logic                    busy;
    logic                    done;
    vec_calc_pkg::mem_req_t  mem_req;
    vec_calc_pkg::mem_rsp_t  mem_rsp;

    logic                    rd_en;
    logic [`VC_ROW_BITS-1:0] rd_row;
    vec_calc_pkg::row_t      rd_a;
    vec_calc_pkg::row_t      rd_b;
    logic                    a_wr_en;
    logic                    b_wr_en;
    logic [`VC_ROW_BITS-1:0] wr_row;
    logic [`VC_UNIT_LEN-1:0] wr_mask;
    vec_calc_pkg::row_t      wr_a;
    vec_calc_pkg::row_t      wr_b;

    vec_calc_pkg::row_pair_t calc_in;
    vec_calc_pkg::row_pair_t calc_out;
    logic                    calc_in_valid;
    logic                    calc_out_valid;

    axil_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .start     (start),
        .cfg_src   (cfg_src),
        .cfg_dst   (cfg_dst),
        .cfg_count (cfg_count),
        .busy      (busy),
        .done      (done),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    calc_sequencer u_seq (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .cfg_src        (cfg_src),
        .cfg_dst        (cfg_dst),
        .cfg_count      (cfg_count),
        .busy           (busy),
        .done           (done),
        .host_req       (mem_req),
        .host_rsp       (mem_rsp),
        .rd_en          (rd_en),
        .rd_row         (rd_row),
        .rd_a           (rd_a),
        .rd_b           (rd_b),
        .a_wr_en        (a_wr_en),
        .b_wr_en        (b_wr_en),
        .wr_row         (wr_row),
        .wr_mask        (wr_mask),
        .wr_a           (wr_a),
        .wr_b           (wr_b),
        .calc_in        (calc_in),
        .calc_in_valid  (calc_in_valid),
        .calc_out       (calc_out),
        .calc_out_valid (calc_out_valid)
    );

    vec_sram bank_a (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_row  (rd_row),
        .rd_data (rd_a),
        .wr_en   (a_wr_en),
        .wr_row  (wr_row),
        .wr_mask (wr_mask),
        .wr_data (wr_a)
    );

    vec_sram bank_b (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_row  (rd_row),
        .rd_data (rd_b),
        .wr_en   (b_wr_en),
        .wr_row  (wr_row),
        .wr_mask (wr_mask),
        .wr_data (wr_b)
    );

    sram_to_sram_calc_unit #(
        .INSERT_PRE_FF  (`VC_PRE_FF),
        .INSERT_POST_FF (`VC_POST_FF)
    ) u_calc (
        .reset   (reset),
        .clk     (clk),
        .s_pair  (calc_in),
        .s_valid (calc_in_valid),
        .m_pair  (calc_out),
        .m_valid (calc_out_valid)
    );

endmodule

`default_nettype wire

// ==== design/vec_sram.sv ====
`default_nettype none

`include "vec_calc_defs.svh"

module vec_sram (
    input  var logic                    clk,

    input  var logic                    rd_en,
    input  var logic [`VC_ROW_BITS-1:0] rd_row,
    output var vec_calc_pkg::row_t      rd_data,

    input  var logic                    wr_en,
    input  var logic [`VC_ROW_BITS-1:0] wr_row,
    input  var logic [`VC_UNIT_LEN-1:0] wr_mask,
    input  var vec_calc_pkg::row_t      wr_data
);

    vec_calc_pkg::row_t mem [2**`VC_ROW_BITS];

    // Read returns the old row when the same row is written in the same cycle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_row];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < `VC_UNIT_LEN; i++) begin
                if (wr_mask[i]) begin
                    mem[wr_row][i] <= wr_data[i];  // Element lanes are independent
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== include/vec_calc_defs.svh ====
`ifndef VEC_CALC_DEFS_SVH
`define VEC_CALC_DEFS_SVH

// ========================================
// Datapath geometry
// ========================================

`define VC_DATA_BITS 8
`define VC_UNIT_LEN 4
`define VC_ROW_BITS 4

// ========================================
// Calc unit pipeline options
// ========================================

`define VC_PRE_FF 0
`define VC_POST_FF 1

// ========================================
// Host bus
// ========================================

`define VC_AXI_ADDR_BITS 12

`endif

// ==== tb/vec_calc_tb.sv ====
`default_nettype none

`include "vec_calc_defs.svh"

module vec_calc_tb;

    localparam int ROWS  = 2 ** `VC_ROW_BITS;
    localparam int LANES = `VC_UNIT_LEN;
    localparam int TIMEOUT_CYCLES = 20000;  // About 700 transactions at ten cycles, three times over

    logic                    clk = 1'b0;
    logic                    reset;
    vec_calc_pkg::axil_req_t req;
    vec_calc_pkg::axil_rsp_t rsp;
    vec_calc_pkg::elem_t     shadow_a [ROWS][LANES];
    vec_calc_pkg::elem_t     shadow_b [ROWS][LANES];
    integer                  seed = 32'hba20_b7ed;
    int                      cycles = 0;
    int                      errors = 0;
    int                      errors_mark = 0;
    int                      tests_ok = 0;
    int                      tests_bad = 0;

    vec_calc_top uut (
        .clk      (clk),
        .reset    (reset),
        .axil_req (req),
        .axil_rsp (rsp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    // ========================================
    // Checks and reference model
    // ========================================

    function automatic logic [31:0] sext(input vec_calc_pkg::elem_t v);
        return int'(v);
    endfunction

    function automatic logic [`VC_AXI_ADDR_BITS-1:0] elem_addr(input logic bank, input int row,
                                                               input int lane);
        return (bank ? 'h200 : 'h100) + row * 16 + lane * 4;
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_mark) begin
            tests_ok++;
            $display("%-24s ok", name);
        end else begin
            tests_bad++;
            $display("%-24s FAILED with %0d mismatches", name, errors - errors_mark);
        end
        errors_mark = errors;
    endtask

    // Each result row comes from the source row pair, wrapped back to the element width
    task automatic model_job(input int src, input int dst, input int count);
        integer a;
        integer b;
        for (int r = 0; r < count; r++) begin
            for (int l = 0; l < LANES; l++) begin
                a = shadow_a[src + r][l];
                b = shadow_b[src + r][l];
                shadow_a[dst + r][l] = a + (b >>> 1);
                shadow_b[dst + r][l] = a + b;
            end
        end
    endtask

    // ========================================
    // AXI4-Lite host tasks
    // ========================================

    task automatic axil_write(input logic [`VC_AXI_ADDR_BITS-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        req.awaddr  = addr;
        req.wdata   = data;
        req.awvalid = 1'b1;
        req.wvalid  = 1'b1;
        @(negedge clk);
        while (!rsp.awready) @(negedge clk);
        check_word(rsp.wready, 32'h1, $sformatf("wready together with awready at %h", addr));
        @(posedge clk);
        #1;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        while (!rsp.bvalid) @(negedge clk);
        resp = rsp.bresp;
        @(posedge clk);  // Bready is held high, so the response is taken here
        #1;
    endtask

    task automatic axil_read(input logic [`VC_AXI_ADDR_BITS-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        @(negedge clk);
        while (!rsp.arready) @(negedge clk);
        @(posedge clk);
        #1;
        req.arvalid = 1'b0;
        while (!rsp.rvalid) @(negedge clk);
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk);
        #1;
    endtask

    task automatic reg_write(input logic [`VC_AXI_ADDR_BITS-1:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_word(resp, 2'b00, $sformatf("write response at %h", addr));
    endtask

    task automatic reg_read_check(input logic [`VC_AXI_ADDR_BITS-1:0] addr,
                                  input logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check_word(resp, 2'b00, $sformatf("read response at %h", addr));
        check_word(data, exp, $sformatf("read data at %h", addr));
    endtask

    task automatic write_elem(input logic bank, input int row, input int lane,
                              input vec_calc_pkg::elem_t value);
        reg_write(elem_addr(bank, row, lane), sext(value));
        if (bank) begin
            shadow_b[row][lane] = value;
        end else begin
            shadow_a[row][lane] = value;
        end
    endtask

    task automatic check_elem(input logic bank, input int row, input int lane);
        reg_read_check(elem_addr(bank, row, lane),
                       sext(bank ? shadow_b[row][lane] : shadow_a[row][lane]));
    endtask

    task automatic check_banks();
        for (int r = 0; r < ROWS; r++) begin
            for (int l = 0; l < LANES; l++) begin
                check_elem(1'b0, r, l);
                check_elem(1'b1, r, l);
            end
        end
    endtask

    task automatic load_rows(input int first, input int last);
        for (int r = first; r <= last; r++) begin
            for (int l = 0; l < LANES; l++) begin
                write_elem(1'b0, r, l, $random(seed));
                write_elem(1'b1, r, l, $random(seed));
            end
        end
    endtask

    task automatic start_job(input int src, input int dst, input int count);
        reg_write(vec_calc_pkg::reg_src_row, src);
        reg_write(vec_calc_pkg::reg_dst_row, dst);
        reg_write(vec_calc_pkg::reg_row_count, count);
        reg_write(vec_calc_pkg::reg_ctrl, 32'h1);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        logic [1:0]  resp;
        status = '0;
        while (status[1:0] != 2'b10) axil_read(vec_calc_pkg::reg_status, status, resp);
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        req         = '0;
        req.wstrb   = 4'hF;
        req.bready  = 1'b1;
        req.rready  = 1'b1;
        reset       = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        reg_read_check(vec_calc_pkg::reg_status, 32'h0);
        reg_write(vec_calc_pkg::reg_src_row, 32'd3);
        reg_write(vec_calc_pkg::reg_dst_row, 32'd9);
        reg_write(vec_calc_pkg::reg_row_count, 32'd5);
        reg_read_check(vec_calc_pkg::reg_src_row, 32'd3);
        reg_read_check(vec_calc_pkg::reg_dst_row, 32'd9);
        reg_read_check(vec_calc_pkg::reg_row_count, 32'd5);
        reg_write('h040, 32'hdead_beef);  // Unmapped, dropped
        reg_read_check('h040, 32'h0);
        finish_test("register access");

        write_elem(1'b0, 1, 2, 8'h80);
        write_elem(1'b1, 3, 0, 8'hFF);
        write_elem(1'b0, 5, 3, 8'h7F);
        write_elem(1'b1, 6, 1, 8'h01);
        check_elem(1'b0, 1, 2);
        check_elem(1'b1, 3, 0);
        check_elem(1'b0, 5, 3);
        check_elem(1'b1, 6, 1);
        finish_test("element window");

        load_rows(0, ROWS - 1);
        start_job(0, 8, 1);
        wait_done();
        model_job(0, 8, 1);
        check_banks();
        finish_test("single row job");

        load_rows(0, 7);
        write_elem(1'b0, 0, 0, 8'h7F);  // Sums past the signed range on purpose
        write_elem(1'b1, 0, 0, 8'h7F);
        write_elem(1'b0, 1, 3, 8'h80);
        write_elem(1'b1, 1, 3, 8'h81);
        start_job(0, 8, 8);
        wait_done();
        model_job(0, 8, 8);
        check_banks();
        finish_test("eight row job");

        start_job(0, 8, 8);
        axil_read(vec_calc_pkg::reg_status, data, resp);
        check_word({31'b0, data[0]}, 32'h1, "busy right after start");
        axil_read(elem_addr(1'b0, 2, 1), data, resp);
        check_word(resp, 2'b10, "window read response while busy");
        axil_write(elem_addr(1'b0, 2, 1), 32'h5A, resp);
        check_word(resp, 2'b10, "window write response while busy");
        wait_done();
        model_job(0, 8, 8);
        check_elem(1'b0, 2, 1);
        finish_test("access while busy");

        reg_write(vec_calc_pkg::reg_row_count, 32'd0);
        reg_write(vec_calc_pkg::reg_ctrl, 32'h1);
        reg_read_check(vec_calc_pkg::reg_status, 32'h2);  // Done kept from the last job
        load_rows(0, 7);
        start_job(0, 8, 4);
        reg_write(vec_calc_pkg::reg_row_count, 32'd8);
        reg_write(vec_calc_pkg::reg_ctrl, 32'h1);
        wait_done();
        model_job(0, 8, 4);
        check_banks();
        finish_test("ignored starts");

        $display("Results: %0d groups ok, %0d groups failing, %0d mismatches",
                 tests_ok, tests_bad, errors);
        if (tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
